// File: src/fsq_pkg.sv
`default_nettype none

package fsq_pkg;

    // instructions per fetch block
    localparam int BLOCK_INST_NUM = 8;

    // backend retire bandwidth
    localparam int COMMIT_WIDTH = 4;

    localparam int VADDR_W = 32;
    localparam int INST_CNT_W = $clog2(BLOCK_INST_NUM);
    localparam int COMMIT_NUM_W = $clog2(COMMIT_WIDTH + 1);

    typedef logic [VADDR_W-1:0] vaddr_t;

    // instructions minus one
    typedef logic [INST_CNT_W-1:0] inst_count_t;

    typedef logic [COMMIT_NUM_W-1:0] commit_num_t;

    typedef struct packed {
        vaddr_t      start_addr;
        inst_count_t size;
        vaddr_t      target;
    } fetch_stream_t;

endpackage

`default_nettype wire

// File: src/stream_enqueue.sv
`timescale 1ns/1ps
`default_nettype none

module stream_enqueue #(
    parameter int QUEUE_DEPTH = 8,
    localparam int PTR_W = $clog2(QUEUE_DEPTH) + 1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pred_valid,
    input  fsq_pkg::fetch_stream_t pred_stream,
    input  logic                   redirect_valid,
    input  logic [PTR_W-1:0]       redirect_ptr,
    input  fsq_pkg::inst_count_t   redirect_offset,
    input  fsq_pkg::vaddr_t        redirect_target,
    input  fsq_pkg::fetch_stream_t redirect_stream,
    input  logic [PTR_W-1:0]       commit_ptr,
    output logic                   pred_stall,
    output logic [PTR_W-1:0]       tail_ptr,
    output logic                   wr_en,
    output logic [PTR_W-1:0]       wr_ptr,
    output fsq_pkg::fetch_stream_t wr_stream
);
    import fsq_pkg::*;

    fetch_stream_t rewrite_stream;
    logic          full;
    logic          enq;

    // same slot, one lap apart
    assign full = (commit_ptr[PTR_W-2:0] == tail_ptr[PTR_W-2:0]) &&
                  (commit_ptr[PTR_W-1] != tail_ptr[PTR_W-1]);
    assign pred_stall = full;

    // backend redirect owns the write port this cycle
    assign enq = pred_valid & ~full & ~redirect_valid;

    // start address stays, the stream now ends at the mispredicted slot
    always_comb begin
        rewrite_stream = redirect_stream;
        rewrite_stream.size = redirect_offset;
        rewrite_stream.target = redirect_target;
    end

    assign wr_en = enq | redirect_valid;
    assign wr_ptr = redirect_valid ? redirect_ptr : tail_ptr;
    assign wr_stream = redirect_valid ? rewrite_stream : pred_stream;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail_ptr <= '0;
        end else if (redirect_valid) begin
            // younger streams are gone
            tail_ptr <= redirect_ptr + 1'b1;
        end else if (enq) begin
            tail_ptr <= tail_ptr + 1'b1;
        end
    end

    // predictor has to honour the stall, else the stream is lost
    a_no_enq_when_full: assert property (
        @(posedge clk) disable iff (rst)
        pred_valid |-> !full
    ) else $error("stream_enqueue: pred_valid while queue full");

endmodule

`default_nettype wire

// File: src/stream_store.sv
`timescale 1ns/1ps
`default_nettype none

module stream_store #(
    parameter int QUEUE_DEPTH = 8,
    localparam int PTR_W = $clog2(QUEUE_DEPTH) + 1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wr_en,
    input  logic [PTR_W-1:0]       wr_ptr,
    input  fsq_pkg::fetch_stream_t wr_stream,
    input  logic [PTR_W-1:0]       search_ptr,
    input  logic [PTR_W-1:0]       commit_ptr,
    input  logic [PTR_W-1:0]       redirect_ptr,
    output fsq_pkg::fetch_stream_t search_stream,
    output fsq_pkg::fetch_stream_t commit_stream,
    output fsq_pkg::fetch_stream_t redirect_stream
);
    import fsq_pkg::*;

    localparam int IDX_W = PTR_W - 1;

    fetch_stream_t           entries [QUEUE_DEPTH];
    logic          [IDX_W-1:0] wr_idx;
    logic          [IDX_W-1:0] search_idx;
    logic          [IDX_W-1:0] commit_idx;
    logic          [IDX_W-1:0] redirect_idx;

    // wrap bit only matters for occupancy
    assign wr_idx = wr_ptr[IDX_W-1:0];
    assign search_idx = search_ptr[IDX_W-1:0];
    assign commit_idx = commit_ptr[IDX_W-1:0];
    assign redirect_idx = redirect_ptr[IDX_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else if (wr_en) begin
            entries[wr_idx] <= wr_stream;
        end
    end

    // cache, retire and redirect views
    assign search_stream = entries[search_idx];
    assign commit_stream = entries[commit_idx];
    assign redirect_stream = entries[redirect_idx];

endmodule

`default_nettype wire

// File: src/fetch_issue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_issue #(
    parameter int QUEUE_DEPTH = 8,
    localparam int PTR_W = $clog2(QUEUE_DEPTH) + 1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [PTR_W-1:0]       tail_ptr,
    input  fsq_pkg::fetch_stream_t search_stream,
    input  logic                   cache_ready,
    input  logic                   redirect_valid,
    input  logic [PTR_W-1:0]       redirect_ptr,
    input  fsq_pkg::inst_count_t   redirect_offset,
    input  fsq_pkg::vaddr_t        redirect_target,
    input  fsq_pkg::fetch_stream_t redirect_stream,
    output logic [PTR_W-1:0]       search_ptr,
    output logic                   cache_valid,
    output logic [PTR_W-1:0]       cache_ptr,
    output fsq_pkg::fetch_stream_t cache_stream,
    output logic                   squash_valid,
    output fsq_pkg::vaddr_t        squash_start,
    output fsq_pkg::inst_count_t   squash_offset,
    output fsq_pkg::vaddr_t        squash_target
);
    logic cache_fire;

    // streams between search and tail still wait for the cache
    assign cache_valid = (search_ptr != tail_ptr) & ~redirect_valid;
    assign cache_ptr = search_ptr;
    assign cache_stream = search_stream;
    assign cache_fire = cache_valid & cache_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            search_ptr <= '0;
        end else if (redirect_valid) begin
            search_ptr <= redirect_ptr + 1'b1;
        end else if (cache_fire) begin
            search_ptr <= search_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            squash_valid <= 1'b0;
        end else begin
            squash_valid <= redirect_valid;
        end
    end

    // squash report for the predictor
    always_ff @(posedge clk) begin
        if (redirect_valid) begin
            squash_start <= redirect_stream.start_addr;
            squash_offset <= redirect_offset;
            squash_target <= redirect_target;
        end
    end

    // a stalled request holds unless a redirect flushes it
    a_cache_hold: assert property (
        @(posedge clk) disable iff (rst)
        cache_valid && !cache_ready |=> redirect_valid ||
            (cache_valid && $stable(cache_ptr) && $stable(cache_stream))
    ) else $error("fetch_issue: cache request changed while stalled");

endmodule

`default_nettype wire

// File: src/stream_commit.sv
`timescale 1ns/1ps
`default_nettype none

module stream_commit #(
    parameter int QUEUE_DEPTH = 8,
    localparam int PTR_W = $clog2(QUEUE_DEPTH) + 1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  fsq_pkg::commit_num_t   commit_num,
    input  logic [PTR_W-1:0]       tail_ptr,
    input  fsq_pkg::fetch_stream_t commit_stream,
    output logic [PTR_W-1:0]       commit_ptr,
    output logic                   update_valid,
    output fsq_pkg::fetch_stream_t update_stream
);
    import fsq_pkg::*;

    // enough for every instruction the queue can hold plus one commit beat
    localparam int ACC_W = $clog2(QUEUE_DEPTH * BLOCK_INST_NUM + COMMIT_WIDTH) + 1;
    localparam int NUM_W = $clog2(BLOCK_INST_NUM) + 1;

    logic [ACC_W-1:0] acc;
    logic [ACC_W:0]   acc_sum;
    logic [NUM_W-1:0] head_num;
    logic             empty;
    logic             retire;

    assign empty = (commit_ptr == tail_ptr);

    // size field is instructions minus one
    assign head_num = {1'b0, commit_stream.size} + 1'b1;

    assign retire = ~empty & (acc >= ACC_W'(head_num));

    always_comb begin
        acc_sum = {1'b0, acc} + (ACC_W + 1)'(commit_num);
        if (retire) begin
            acc_sum = acc_sum - (ACC_W + 1)'(head_num);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
            commit_ptr <= '0;
        end else begin
            acc <= acc_sum[ACC_W-1:0];
            if (retire) begin
                commit_ptr <= commit_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            update_valid <= 1'b0;
        end else begin
            update_valid <= retire;
        end
    end

    // training data for the predictor
    always_ff @(posedge clk) begin
        if (retire) begin
            update_stream <= commit_stream;
        end
    end

    // commit may never run past the tail
    a_occupancy: assert property (
        @(posedge clk) disable iff (rst)
        PTR_W'(tail_ptr - commit_ptr) <= PTR_W'(QUEUE_DEPTH)
    ) else $error("stream_commit: commit pointer passed the tail");

    a_acc_range: assert property (
        @(posedge clk) disable iff (rst)
        !acc_sum[ACC_W]
    ) else $error("stream_commit: commit accumulator overflow");

endmodule

`default_nettype wire

// File: src/fsq_top.sv
`timescale 1ns/1ps
`default_nettype none

module fsq_top #(
    parameter int QUEUE_DEPTH = 8,
    localparam int PTR_W = $clog2(QUEUE_DEPTH) + 1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pred_valid,
    input  fsq_pkg::fetch_stream_t pred_stream,
    output logic                   pred_stall,
    output logic [PTR_W-1:0]       pred_ptr,
    output logic                   cache_valid,
    input  logic                   cache_ready,
    output logic [PTR_W-1:0]       cache_ptr,
    output fsq_pkg::fetch_stream_t cache_stream,
    input  logic                   redirect_valid,
    input  logic [PTR_W-1:0]       redirect_ptr,
    input  fsq_pkg::inst_count_t   redirect_offset,
    input  fsq_pkg::vaddr_t        redirect_target,
    input  fsq_pkg::commit_num_t   commit_num,
    output logic                   squash_valid,
    output fsq_pkg::vaddr_t        squash_start,
    output fsq_pkg::inst_count_t   squash_offset,
    output fsq_pkg::vaddr_t        squash_target,
    output logic                   update_valid,
    output fsq_pkg::fetch_stream_t update_stream
);
    import fsq_pkg::*;

    logic             wr_en;
    logic [PTR_W-1:0] wr_ptr;
    fetch_stream_t    wr_stream;
    logic [PTR_W-1:0] search_ptr;
    logic [PTR_W-1:0] commit_ptr;
    fetch_stream_t    search_stream;
    fetch_stream_t    commit_stream;
    fetch_stream_t    redirect_stream;

    // tail pointer doubles as the id of the next predicted stream
    stream_enqueue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_stream_enqueue (
        .clk            (clk),
        .rst            (rst),
        .pred_valid     (pred_valid),
        .pred_stream    (pred_stream),
        .redirect_valid (redirect_valid),
        .redirect_ptr   (redirect_ptr),
        .redirect_offset(redirect_offset),
        .redirect_target(redirect_target),
        .redirect_stream(redirect_stream),
        .commit_ptr     (commit_ptr),
        .pred_stall     (pred_stall),
        .tail_ptr       (pred_ptr),
        .wr_en          (wr_en),
        .wr_ptr         (wr_ptr),
        .wr_stream      (wr_stream)
    );

    stream_store #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_stream_store (
        .clk            (clk),
        .rst            (rst),
        .wr_en          (wr_en),
        .wr_ptr         (wr_ptr),
        .wr_stream      (wr_stream),
        .search_ptr     (search_ptr),
        .commit_ptr     (commit_ptr),
        .redirect_ptr   (redirect_ptr),
        .search_stream  (search_stream),
        .commit_stream  (commit_stream),
        .redirect_stream(redirect_stream)
    );

    fetch_issue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_fetch_issue (
        .clk            (clk),
        .rst            (rst),
        .tail_ptr       (pred_ptr),
        .search_stream  (search_stream),
        .cache_ready    (cache_ready),
        .redirect_valid (redirect_valid),
        .redirect_ptr   (redirect_ptr),
        .redirect_offset(redirect_offset),
        .redirect_target(redirect_target),
        .redirect_stream(redirect_stream),
        .search_ptr     (search_ptr),
        .cache_valid    (cache_valid),
        .cache_ptr      (cache_ptr),
        .cache_stream   (cache_stream),
        .squash_valid   (squash_valid),
        .squash_start   (squash_start),
        .squash_offset  (squash_offset),
        .squash_target  (squash_target)
    );

    stream_commit #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_stream_commit (
        .clk          (clk),
        .rst          (rst),
        .commit_num   (commit_num),
        .tail_ptr     (pred_ptr),
        .commit_stream(commit_stream),
        .commit_ptr   (commit_ptr),
        .update_valid (update_valid),
        .update_stream(update_stream)
    );

endmodule

`default_nettype wire

// File: bench/fsq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fsq_tb;
    import fsq_pkg::*;

    localparam int QUEUE_DEPTH = 8;
    localparam int PTR_W = $clog2(QUEUE_DEPTH) + 1;
    localparam int WAIT_LIMIT = 32;

    logic             clk;
    logic             rst;
    logic             pred_valid;
    fetch_stream_t    pred_stream;
    logic             pred_stall;
    logic [PTR_W-1:0] pred_ptr;
    logic             cache_valid;
    logic             cache_ready;
    logic [PTR_W-1:0] cache_ptr;
    fetch_stream_t    cache_stream;
    logic             redirect_valid;
    logic [PTR_W-1:0] redirect_ptr;
    inst_count_t      redirect_offset;
    vaddr_t           redirect_target;
    commit_num_t      commit_num;
    logic             squash_valid;
    vaddr_t           squash_start;
    inst_count_t      squash_offset;
    vaddr_t           squash_target;
    logic             update_valid;
    fetch_stream_t    update_stream;

    int                error_count;
    int                mark_errors;
    int                test_count;
    int                failed_tests;
    int                fd;
    int                code;
    logic [7:0]        cmd;
    logic [31:0]       v0;
    logic [31:0]       v1;
    logic [31:0]       v2;
    logic [31:0]       v3;
    logic [31:0]       v4;
    logic [8*128-1:0]  line;

    fsq_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_fsq_top (
        .clk            (clk),
        .rst            (rst),
        .pred_valid     (pred_valid),
        .pred_stream    (pred_stream),
        .pred_stall     (pred_stall),
        .pred_ptr       (pred_ptr),
        .cache_valid    (cache_valid),
        .cache_ready    (cache_ready),
        .cache_ptr      (cache_ptr),
        .cache_stream   (cache_stream),
        .redirect_valid (redirect_valid),
        .redirect_ptr   (redirect_ptr),
        .redirect_offset(redirect_offset),
        .redirect_target(redirect_target),
        .commit_num     (commit_num),
        .squash_valid   (squash_valid),
        .squash_start   (squash_start),
        .squash_offset  (squash_offset),
        .squash_target  (squash_target),
        .update_valid   (update_valid),
        .update_stream  (update_stream)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_cache(input logic [31:0] ptr, input logic [31:0] start,
                               input logic [31:0] size, input logic [31:0] target);
        check_value("cache_ptr", 64'(cache_ptr), 64'(ptr));
        check_value("cache_stream.start_addr", 64'(cache_stream.start_addr), 64'(start));
        check_value("cache_stream.size", 64'(cache_stream.size), 64'(size));
        check_value("cache_stream.target", 64'(cache_stream.target), 64'(target));
    endtask

    task automatic send_stream(input logic [31:0] start, input logic [31:0] size,
                               input logic [31:0] target, input logic [31:0] ptr);
        int waited;
        waited = 0;
        @(negedge clk);
        while (pred_stall && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (pred_stall) begin
            $display("pred_stall stayed high, stream %0d was never sent", ptr);
            error_count++;
        end else begin
            check_value("pred_ptr", 64'(pred_ptr), 64'(ptr));
            @(posedge clk);
            pred_valid <= 1'b1;
            pred_stream.start_addr <= start;
            pred_stream.size <= inst_count_t'(size);
            pred_stream.target <= target;
            @(posedge clk);
            pred_valid <= 1'b0;
        end
    endtask

    // hold ready low for a number of cycles, then take the stream
    task automatic take_stream(input logic [31:0] hold, input logic [31:0] ptr,
                               input logic [31:0] start, input logic [31:0] size,
                               input logic [31:0] target);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!cache_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!cache_valid) begin
            $display("cache_valid never rose for stream %0d", ptr);
            error_count++;
        end else begin
            check_cache(ptr, start, size, target);
            for (int i = 0; i < int'(hold); i++) begin
                @(negedge clk);
                check_value("cache_valid", 64'(cache_valid), 64'd1);
                check_cache(ptr, start, size, target);
            end
            @(posedge clk);
            cache_ready <= 1'b1;
            @(posedge clk);
            cache_ready <= 1'b0;
        end
    endtask

    task automatic send_redirect(input logic [31:0] ptr, input logic [31:0] offset,
                                 input logic [31:0] target, input logic [31:0] start);
        @(posedge clk);
        redirect_valid <= 1'b1;
        redirect_ptr <= PTR_W'(ptr);
        redirect_offset <= inst_count_t'(offset);
        redirect_target <= target;
        @(negedge clk);
        check_value("cache_valid", 64'(cache_valid), 64'd0);
        check_value("squash_valid", 64'(squash_valid), 64'd0);
        @(posedge clk);
        redirect_valid <= 1'b0;
        @(negedge clk);
        check_value("squash_valid", 64'(squash_valid), 64'd1);
        check_value("squash_start", 64'(squash_start), 64'(start));
        check_value("squash_offset", 64'(squash_offset), 64'(offset));
        check_value("squash_target", 64'(squash_target), 64'(target));
        @(negedge clk);
        check_value("squash_valid", 64'(squash_valid), 64'd0);
    endtask

    // count lands at the next edge, the update one edge after the retire cycle
    task automatic send_commit(input logic [31:0] num, input logic [31:0] exp_valid,
                               input logic [31:0] start, input logic [31:0] size,
                               input logic [31:0] target);
        @(posedge clk);
        commit_num <= commit_num_t'(num);
        @(posedge clk);
        commit_num <= '0;
        @(posedge clk);
        @(negedge clk);
        check_value("update_valid", 64'(update_valid), 64'(exp_valid != 0));
        if (exp_valid != 0) begin
            check_value("update_stream.start_addr", 64'(update_stream.start_addr),
                        64'(start));
            check_value("update_stream.size", 64'(update_stream.size), 64'(size));
            check_value("update_stream.target", 64'(update_stream.target), 64'(target));
        end
    endtask

    task automatic close_test(input logic [31:0] id);
        test_count++;
        if (error_count == mark_errors) begin
            $display("test %0d ok", id);
        end else begin
            failed_tests++;
            $display("test %0d failed with %0d errors", id, error_count - mark_errors);
        end
        mark_errors = error_count;
    endtask

    task automatic report_bad_line(input logic [7:0] c);
        $display("malformed %c line in stimulus file", c);
        error_count++;
    endtask

    initial begin
        rst = 1'b1;
        pred_valid = 1'b0;
        pred_stream = '0;
        cache_ready = 1'b0;
        redirect_valid = 1'b0;
        redirect_ptr = '0;
        redirect_offset = '0;
        redirect_target = '0;
        commit_num = '0;
        error_count = 0;
        mark_errors = 0;
        test_count = 0;
        failed_tests = 0;

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("cache_valid", 64'(cache_valid), 64'd0);
        check_value("squash_valid", 64'(squash_valid), 64'd0);
        check_value("update_valid", 64'(update_valid), 64'd0);
        check_value("pred_stall", 64'(pred_stall), 64'd0);
        close_test(0);

        fd = $fopen("bench/fsq_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/fsq_stimulus.txt");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", cmd);
                if (code == 1) begin
                    case (cmd)
                        "#": code = $fgets(line, fd);
                        "P": begin
                            if ($fscanf(fd, "%h %h %h %h", v0, v1, v2, v3) == 4)
                                send_stream(v0, v1, v2, v3);
                            else
                                report_bad_line(cmd);
                        end
                        "F": begin
                            if ($fscanf(fd, "%h %h %h %h %h", v0, v1, v2, v3, v4) == 5)
                                take_stream(v0, v1, v2, v3, v4);
                            else
                                report_bad_line(cmd);
                        end
                        "R": begin
                            if ($fscanf(fd, "%h %h %h %h", v0, v1, v2, v3) == 4)
                                send_redirect(v0, v1, v2, v3);
                            else
                                report_bad_line(cmd);
                        end
                        "C": begin
                            if ($fscanf(fd, "%h %h %h %h %h", v0, v1, v2, v3, v4) == 5)
                                send_commit(v0, v1, v2, v3, v4);
                            else
                                report_bad_line(cmd);
                        end
                        "S": begin
                            if ($fscanf(fd, "%h", v0) == 1) begin
                                @(negedge clk);
                                check_value("pred_stall", 64'(pred_stall), 64'(v0));
                            end else begin
                                report_bad_line(cmd);
                            end
                        end
                        "E": begin
                            if ($fscanf(fd, "%h", v0) == 1)
                                close_test(v0);
                            else
                                report_bad_line(cmd);
                        end
                        default: begin
                            $display("unknown command %c in stimulus file", cmd);
                            error_count++;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        $display("tests: %0d run, %0d failed, %0d errors", test_count, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/fsq_stimulus.txt
# all values hex; P start size target exp_ptr, F hold exp_ptr start size target, S stall
# R ptr offset target exp_start, C num exp_update start size target, E test_id
# test 1: enqueue and fetch in order
P 1000 3 2000 0
P 2000 7 3000 1
P 3000 1 1000 2
F 0 0 1000 3 2000
F 0 1 2000 7 3000
E 1
# test 2: cache ready held low
F 3 2 3000 1 1000
E 2
# test 3: full queue stalls the predictor until the head retires
P 4000 0 4100 3
P 5000 1 5100 4
P 6000 2 6100 5
P 7000 3 7100 6
P 8000 4 8100 7
S 1
C 4 1 1000 3 2000
S 0
E 3
# test 4: redirect of stream 5 squashes 6 and 7
F 0 3 4000 0 4100
F 0 4 5000 1 5100
F 0 5 6000 2 6100
R 5 1 9000 6000
P a000 5 a100 6
F 0 6 a000 5 a100
E 4
# test 5: commit counts spread over cycles, leftover carries
C 3 0 0 0 0
C 3 0 0 0 0
C 3 1 2000 7 3000
C 1 1 3000 1 1000
C 1 1 4000 0 4100
C 2 1 5000 1 5100
C 2 1 6000 1 9000
S 0
E 5

// File: flist.f
src/fsq_pkg.sv
src/stream_enqueue.sv
src/stream_store.sv
src/fetch_issue.sv
src/stream_commit.sv
src/fsq_top.sv
bench/fsq_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the fsq testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module fsq_tb -f flist.f -o fsq_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/fsq_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
